// ==== source/rv_pkg.sv ====
package rv_pkg;

  localparam int unsigned xlen = 32;
  localparam int unsigned reg_addr_w = 4;
  localparam int unsigned reg_num = 16;
  localparam logic [xlen-1:0] pc_reset = '0;

  // Major opcodes in inst[6:0]
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_branch = 7'b1100011,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_slt,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    fetch_idle,
    fetch_request,
    fetch_hand_off,
    fetch_wait_retire
  } fetch_state_e;

  typedef enum logic [1:0] {
    exec_idle,
    exec_compute,
    exec_mem_access,
    exec_halted
  } exec_state_e;

endpackage

// ==== source/rv_regfile.sv ====
`timescale 1ns/10ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          we_i,
  input  logic [rv_pkg::reg_addr_w-1:0] waddr_i,
  input  logic [rv_pkg::xlen-1:0]       wdata_i,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr1_i,
  input  logic [rv_pkg::reg_addr_w-1:0] raddr2_i,
  output logic [rv_pkg::xlen-1:0]       rdata1_o,
  output logic [rv_pkg::xlen-1:0]       rdata2_o
);

  logic [rv_pkg::xlen-1:0] regs_q [rv_pkg::reg_num];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < rv_pkg::reg_num; i++)
        regs_q[i] <= '0;
    end
    // Entry 0 keeps its reset value of zero
    else if (we_i && waddr_i != '0)
      regs_q[waddr_i] <= wdata_i;
  end

  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

endmodule

// ==== source/rv_bus_arbiter.sv ====
`timescale 1ns/10ps

module rv_bus_arbiter (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    fetch_req_i,
  input  logic [rv_pkg::xlen-1:0] fetch_addr_i,
  input  logic                    ls_req_i,
  input  logic                    ls_we_i,
  input  logic [rv_pkg::xlen-1:0] ls_addr_i,
  input  logic [rv_pkg::xlen-1:0] ls_wdata_i,
  input  logic                    mem_ack_i,
  input  logic [rv_pkg::xlen-1:0] mem_rdata_i,
  output logic                    fetch_ack_o,
  output logic [rv_pkg::xlen-1:0] fetch_rdata_o,
  output logic                    ls_ack_o,
  output logic [rv_pkg::xlen-1:0] ls_rdata_o,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output logic [rv_pkg::xlen-1:0] mem_addr_o,
  output logic [rv_pkg::xlen-1:0] mem_wdata_o
);

  // At most one of these is set
  logic own_fetch_q;
  logic own_ls_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      own_fetch_q <= 1'b0;
      own_ls_q <= 1'b0;
    end
    else if (own_fetch_q || own_ls_q)
    begin
      // Releasing the grant on ack leaves one idle cycle on the port
      if (mem_ack_i)
      begin
        own_fetch_q <= 1'b0;
        own_ls_q <= 1'b0;
      end
    end
    else
    begin
      // Load/store wins a tie
      own_ls_q <= ls_req_i;
      own_fetch_q <= fetch_req_i && !ls_req_i;
    end
  end

  assign mem_req_o = own_fetch_q || own_ls_q;
  assign mem_we_o = own_ls_q && ls_we_i;
  assign mem_addr_o = own_ls_q ? ls_addr_i : fetch_addr_i;
  assign mem_wdata_o = own_ls_q ? ls_wdata_i : '0;

  assign fetch_ack_o = own_fetch_q && mem_ack_i;
  assign fetch_rdata_o = own_fetch_q ? mem_rdata_i : '0;
  assign ls_ack_o = own_ls_q && mem_ack_i;
  assign ls_rdata_o = own_ls_q ? mem_rdata_i : '0;

endmodule

// ==== source/rv_fetch.sv ====
`timescale 1ns/10ps

module rv_fetch (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    retire_i,
  input  logic [rv_pkg::xlen-1:0] next_pc_i,
  input  logic                    halt_i,
  input  logic                    fetch_ack_i,
  input  logic [rv_pkg::xlen-1:0] fetch_rdata_i,
  output logic                    fetch_req_o,
  output logic [rv_pkg::xlen-1:0] fetch_addr_o,
  output logic                    inst_valid_o,
  output logic [31:0]             inst_o,
  output logic [rv_pkg::xlen-1:0] pc_o
);

  rv_pkg::fetch_state_e    state_q;
  logic [rv_pkg::xlen-1:0] pc_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= rv_pkg::fetch_idle;
      pc_q <= rv_pkg::pc_reset;
    end
    else
    begin
      if (retire_i)
        pc_q <= next_pc_i;
      case (state_q)
        rv_pkg::fetch_idle:
          if (!halt_i)
            state_q <= rv_pkg::fetch_request;
        rv_pkg::fetch_request:
          if (fetch_ack_i)
            state_q <= rv_pkg::fetch_hand_off;
        rv_pkg::fetch_hand_off:
          state_q <= rv_pkg::fetch_wait_retire;
        default:
          // EBREAK never retires, so halt parks the fetch in idle
          if (retire_i)
            state_q <= rv_pkg::fetch_request;
          else if (halt_i)
            state_q <= rv_pkg::fetch_idle;
      endcase
    end
  end

  // Word stays put for decode and register reads until the next fetch
  always_ff @(posedge clk)
  begin
    if (state_q == rv_pkg::fetch_request && fetch_ack_i)
      inst_o <= fetch_rdata_i;
  end

  assign fetch_req_o = state_q == rv_pkg::fetch_request;
  assign fetch_addr_o = pc_q;
  assign inst_valid_o = state_q == rv_pkg::fetch_hand_off;
  assign pc_o = pc_q;

endmodule

// ==== source/rv_decode.sv ====
`timescale 1ns/10ps

module rv_decode (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          inst_valid_i,
  input  logic [31:0]                   inst_i,
  input  logic [rv_pkg::xlen-1:0]       pc_i,
  input  logic [rv_pkg::xlen-1:0]       rs1_data_i,
  input  logic [rv_pkg::xlen-1:0]       rs2_data_i,
  output logic [rv_pkg::reg_addr_w-1:0] rs1_addr_o,
  output logic [rv_pkg::reg_addr_w-1:0] rs2_addr_o,
  output logic                          dec_valid_o,
  output rv_pkg::opcode_e               opcode_o,
  output rv_pkg::alu_op_e               alu_op_o,
  output logic [rv_pkg::xlen-1:0]       op_a_o,
  output logic [rv_pkg::xlen-1:0]       op_b_o,
  output logic [rv_pkg::xlen-1:0]       store_data_o,
  output logic [rv_pkg::xlen-1:0]       imm_o,
  output logic [rv_pkg::xlen-1:0]       pc_o,
  output logic [rv_pkg::reg_addr_w-1:0] rd_o,
  output logic                          rd_we_o,
  output logic                          branch_ne_o
);

  logic [2:0]                    funct3;
  logic [6:0]                    funct7;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic [rv_pkg::xlen-1:0]       imm_i_type;
  logic [rv_pkg::xlen-1:0]       imm_s_type;
  logic [rv_pkg::xlen-1:0]       imm_b_type;
  logic [rv_pkg::xlen-1:0]       imm_u_type;
  logic [rv_pkg::xlen-1:0]       imm_j_type;
  rv_pkg::opcode_e               opcode_d;
  rv_pkg::alu_op_e               alu_op_d;
  logic [rv_pkg::xlen-1:0]       op_b_d;
  logic [rv_pkg::xlen-1:0]       imm_d;
  logic                          rd_we_d;

  // RV32E keeps only the low four bits of each register field
  assign rs1_addr_o = inst_i[18:15];
  assign rs2_addr_o = inst_i[23:20];
  assign rd = inst_i[10:7];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                       inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u_type = {inst_i[31:12], 12'b0};
  assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                       inst_i[20], inst_i[30:21], 1'b0};

  always_comb
  begin
    // Unknown encodings fall through as an op_imm that writes nothing
    opcode_d = rv_pkg::opc_op_imm;
    alu_op_d = rv_pkg::alu_add;
    op_b_d = imm_i_type;
    imm_d = imm_i_type;
    rd_we_d = 1'b0;
    case (inst_i[6:0])
      rv_pkg::opc_lui:
      begin
        opcode_d = rv_pkg::opc_lui;
        alu_op_d = rv_pkg::alu_pass_b;
        op_b_d = imm_u_type;
        imm_d = imm_u_type;
        rd_we_d = 1'b1;
      end
      rv_pkg::opc_op_imm:
      begin
        rd_we_d = 1'b1;
        case (funct3)
          3'b000: alu_op_d = rv_pkg::alu_add;
          3'b100: alu_op_d = rv_pkg::alu_xor;
          3'b110: alu_op_d = rv_pkg::alu_or;
          3'b111: alu_op_d = rv_pkg::alu_and;
          default: rd_we_d = 1'b0;
        endcase
      end
      rv_pkg::opc_op:
      begin
        opcode_d = rv_pkg::opc_op;
        op_b_d = rs2_data_i;
        rd_we_d = funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000);
        case (funct3)
          3'b000: alu_op_d = funct7[5] ? rv_pkg::alu_sub : rv_pkg::alu_add;
          3'b010: alu_op_d = rv_pkg::alu_slt;
          3'b100: alu_op_d = rv_pkg::alu_xor;
          3'b110: alu_op_d = rv_pkg::alu_or;
          3'b111: alu_op_d = rv_pkg::alu_and;
          default: rd_we_d = 1'b0;
        endcase
      end
      rv_pkg::opc_load:
        if (funct3 == 3'b010)
        begin
          opcode_d = rv_pkg::opc_load;
          rd_we_d = 1'b1;
        end
      rv_pkg::opc_store:
        if (funct3 == 3'b010)
        begin
          opcode_d = rv_pkg::opc_store;
          op_b_d = imm_s_type;
          imm_d = imm_s_type;
        end
      rv_pkg::opc_branch:
        // BEQ and BNE only
        if (funct3[2:1] == 2'b00)
        begin
          opcode_d = rv_pkg::opc_branch;
          alu_op_d = rv_pkg::alu_sub;
          op_b_d = rs2_data_i;
          imm_d = imm_b_type;
        end
      rv_pkg::opc_jal:
      begin
        opcode_d = rv_pkg::opc_jal;
        imm_d = imm_j_type;
        rd_we_d = 1'b1;
      end
      rv_pkg::opc_system:
        if (inst_i == 32'h0010_0073)
          opcode_d = rv_pkg::opc_system;
      default:
        opcode_d = rv_pkg::opc_op_imm;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      dec_valid_o <= 1'b0;
    else
      dec_valid_o <= inst_valid_i;
  end

  always_ff @(posedge clk)
  begin
    if (inst_valid_i)
    begin
      opcode_o <= opcode_d;
      alu_op_o <= alu_op_d;
      op_a_o <= rs1_data_i;
      op_b_o <= op_b_d;
      store_data_o <= rs2_data_i;
      imm_o <= imm_d;
      pc_o <= pc_i;
      rd_o <= rd;
      // x0 is never a destination
      rd_we_o <= rd_we_d && rd != '0;
      branch_ne_o <= funct3[0];
    end
  end

endmodule

// ==== source/rv_execute.sv ====
`timescale 1ns/10ps

module rv_execute (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          dec_valid_i,
  input  rv_pkg::opcode_e               opcode_i,
  input  rv_pkg::alu_op_e               alu_op_i,
  input  logic [rv_pkg::xlen-1:0]       op_a_i,
  input  logic [rv_pkg::xlen-1:0]       op_b_i,
  input  logic [rv_pkg::xlen-1:0]       store_data_i,
  input  logic [rv_pkg::xlen-1:0]       imm_i,
  input  logic [rv_pkg::xlen-1:0]       pc_i,
  input  logic [rv_pkg::reg_addr_w-1:0] rd_i,
  input  logic                          rd_we_i,
  input  logic                          branch_ne_i,
  input  logic                          ls_ack_i,
  input  logic [rv_pkg::xlen-1:0]       ls_rdata_i,
  output logic                          ls_req_o,
  output logic                          ls_we_o,
  output logic [rv_pkg::xlen-1:0]       ls_addr_o,
  output logic [rv_pkg::xlen-1:0]       ls_wdata_o,
  output logic                          retire_o,
  output logic [rv_pkg::xlen-1:0]       next_pc_o,
  output logic [rv_pkg::reg_addr_w-1:0] rd_o,
  output logic                          rd_we_o,
  output logic [rv_pkg::xlen-1:0]       rd_data_o,
  output logic                          halt_o
);

  rv_pkg::exec_state_e     state_q;
  logic [rv_pkg::xlen-1:0] alu_res;
  logic [rv_pkg::xlen-1:0] link_pc;
  logic [rv_pkg::xlen-1:0] load_q;
  logic                    taken;

  always_comb
  begin
    case (alu_op_i)
      rv_pkg::alu_add: alu_res = op_a_i + op_b_i;
      rv_pkg::alu_sub: alu_res = op_a_i - op_b_i;
      rv_pkg::alu_and: alu_res = op_a_i & op_b_i;
      rv_pkg::alu_or:  alu_res = op_a_i | op_b_i;
      rv_pkg::alu_xor: alu_res = op_a_i ^ op_b_i;
      rv_pkg::alu_slt:
        alu_res = {{(rv_pkg::xlen-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
      default: alu_res = op_b_i;
    endcase
  end

  // BEQ when branch_ne is clear, BNE when set
  assign taken = opcode_i == rv_pkg::opc_branch && ((op_a_i == op_b_i) != branch_ne_i);
  assign link_pc = pc_i + 32'd4;
  assign next_pc_o = (taken || opcode_i == rv_pkg::opc_jal) ? pc_i + imm_i : link_pc;

  always_ff @(posedge clk)
  begin
    if (rst)
      state_q <= rv_pkg::exec_idle;
    else
    begin
      case (state_q)
        rv_pkg::exec_idle:
          if (dec_valid_i)
          begin
            if (opcode_i == rv_pkg::opc_load || opcode_i == rv_pkg::opc_store)
              state_q <= rv_pkg::exec_mem_access;
            else if (opcode_i == rv_pkg::opc_system)
              state_q <= rv_pkg::exec_halted;
            else
              state_q <= rv_pkg::exec_compute;
          end
        rv_pkg::exec_compute:
          state_q <= rv_pkg::exec_idle;
        rv_pkg::exec_mem_access:
          if (ls_ack_i)
            state_q <= rv_pkg::exec_compute;
        default:
          state_q <= rv_pkg::exec_halted;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == rv_pkg::exec_mem_access && ls_ack_i)
      load_q <= ls_rdata_i;
  end

  // Address and data hold steady while the access waits for its ack
  assign ls_req_o = state_q == rv_pkg::exec_mem_access;
  assign ls_we_o = opcode_i == rv_pkg::opc_store;
  assign ls_addr_o = alu_res;
  assign ls_wdata_o = store_data_i;

  assign retire_o = state_q == rv_pkg::exec_compute;
  assign rd_o = rd_i;
  assign rd_we_o = retire_o && rd_we_i;
  assign rd_data_o = opcode_i == rv_pkg::opc_load ? load_q :
                     opcode_i == rv_pkg::opc_jal  ? link_pc : alu_res;
  assign halt_o = state_q == rv_pkg::exec_halted;

endmodule

// ==== source/rv_core.sv ====
`timescale 1ns/10ps

module rv_core (
  input  logic                    clk,
  input  logic                    rst,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output logic [rv_pkg::xlen-1:0] mem_addr_o,
  output logic [rv_pkg::xlen-1:0] mem_wdata_o,
  input  logic                    mem_ack_i,
  input  logic [rv_pkg::xlen-1:0] mem_rdata_i,
  output logic                    halt_o
);

  logic                          fetch_req;
  logic [rv_pkg::xlen-1:0]       fetch_addr;
  logic                          fetch_ack;
  logic [rv_pkg::xlen-1:0]       fetch_rdata;
  logic                          ls_req;
  logic                          ls_we;
  logic [rv_pkg::xlen-1:0]       ls_addr;
  logic [rv_pkg::xlen-1:0]       ls_wdata;
  logic                          ls_ack;
  logic [rv_pkg::xlen-1:0]       ls_rdata;

  logic                          inst_valid;
  logic [31:0]                   inst;
  logic [rv_pkg::xlen-1:0]       fetch_pc;
  logic                          retire;
  logic [rv_pkg::xlen-1:0]       next_pc;

  logic [rv_pkg::reg_addr_w-1:0] rs1_addr;
  logic [rv_pkg::reg_addr_w-1:0] rs2_addr;
  logic [rv_pkg::xlen-1:0]       rs1_data;
  logic [rv_pkg::xlen-1:0]       rs2_data;

  logic                          dec_valid;
  rv_pkg::opcode_e               opcode;
  rv_pkg::alu_op_e               alu_op;
  logic [rv_pkg::xlen-1:0]       op_a;
  logic [rv_pkg::xlen-1:0]       op_b;
  logic [rv_pkg::xlen-1:0]       store_data;
  logic [rv_pkg::xlen-1:0]       imm;
  logic [rv_pkg::xlen-1:0]       dec_pc;
  logic [rv_pkg::reg_addr_w-1:0] dec_rd;
  logic                          dec_rd_we;
  logic                          branch_ne;

  logic [rv_pkg::reg_addr_w-1:0] wb_rd;
  logic                          wb_we;
  logic [rv_pkg::xlen-1:0]       wb_data;

  rv_fetch u_fetch (
    .clk(clk), .rst(rst),
    .retire_i(retire), .next_pc_i(next_pc), .halt_i(halt_o),
    .fetch_ack_i(fetch_ack), .fetch_rdata_i(fetch_rdata),
    .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr),
    .inst_valid_o(inst_valid), .inst_o(inst), .pc_o(fetch_pc)
  );

  rv_decode u_decode (
    .clk(clk), .rst(rst),
    .inst_valid_i(inst_valid), .inst_i(inst), .pc_i(fetch_pc),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .dec_valid_o(dec_valid), .opcode_o(opcode), .alu_op_o(alu_op),
    .op_a_o(op_a), .op_b_o(op_b), .store_data_o(store_data), .imm_o(imm),
    .pc_o(dec_pc), .rd_o(dec_rd), .rd_we_o(dec_rd_we), .branch_ne_o(branch_ne)
  );

  rv_execute u_execute (
    .clk(clk), .rst(rst),
    .dec_valid_i(dec_valid), .opcode_i(opcode), .alu_op_i(alu_op),
    .op_a_i(op_a), .op_b_i(op_b), .store_data_i(store_data), .imm_i(imm),
    .pc_i(dec_pc), .rd_i(dec_rd), .rd_we_i(dec_rd_we), .branch_ne_i(branch_ne),
    .ls_ack_i(ls_ack), .ls_rdata_i(ls_rdata),
    .ls_req_o(ls_req), .ls_we_o(ls_we), .ls_addr_o(ls_addr), .ls_wdata_o(ls_wdata),
    .retire_o(retire), .next_pc_o(next_pc),
    .rd_o(wb_rd), .rd_we_o(wb_we), .rd_data_o(wb_data), .halt_o(halt_o)
  );

  rv_regfile u_regfile (
    .clk(clk), .rst(rst),
    .we_i(wb_we), .waddr_i(wb_rd), .wdata_i(wb_data),
    .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
    .rdata1_o(rs1_data), .rdata2_o(rs2_data)
  );

  rv_bus_arbiter u_bus_arbiter (
    .clk(clk), .rst(rst),
    .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
    .ls_req_i(ls_req), .ls_we_i(ls_we), .ls_addr_i(ls_addr), .ls_wdata_i(ls_wdata),
    .mem_ack_i(mem_ack_i), .mem_rdata_i(mem_rdata_i),
    .fetch_ack_o(fetch_ack), .fetch_rdata_o(fetch_rdata),
    .ls_ack_o(ls_ack), .ls_rdata_o(ls_rdata),
    .mem_req_o(mem_req_o), .mem_we_o(mem_we_o),
    .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o)
  );

endmodule

// ==== test/tb_rv_core.sv ====
`timescale 1ns/10ps

module tb_rv_core;

  localparam int mem_words = 256;
  localparam int max_checks = 64;
  localparam int inst_per_word = 20;
  localparam int cycles_per_inst = 8;
  localparam int drain_cycles = 3 * cycles_per_inst;

  logic        clk;
  logic        rst;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic        mem_ack;
  logic [31:0] mem_rdata;
  logic        halt;

  logic [31:0]     mem [mem_words];
  logic [8*16-1:0] check_name [max_checks];
  logic [7:0]      check_addr [max_checks];
  logic [31:0]     check_value [max_checks];
  int              check_count;
  int              prog_words;
  int              cycle_limit;
  int              cycle_count;
  int              pass_count;
  int              fail_count;
  logic [31:0]     rng_state;
  int              wait_left;

  rv_core u_rv_core (
    .clk(clk), .rst(rst),
    .mem_req_o(mem_req), .mem_we_o(mem_we),
    .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata),
    .halt_o(halt)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // P lines fill program words and E lines add expected words
  // A # token skips the rest of its line
  task automatic read_data_file();
    int              fd;
    int              n;
    logic [8*16-1:0] tag;
    logic [8*16-1:0] name;
    logic [8*96-1:0] rest;
    logic [31:0]     addr;
    logic [31:0]     word;
    fd = $fopen("test/rv_testdata.txt", "r");
    assert (fd != 0) else
    begin
      $display("Could not open test/rv_testdata.txt");
      fail_count++;
    end
    if (fd != 0)
    begin
      while (!$feof(fd))
      begin
        n = $fscanf(fd, "%s", tag);
        if (n == 1 && tag == "#")
          n = $fgets(rest, fd);
        else if (n == 1 && tag == "P")
        begin
          n = $fscanf(fd, "%h %h", addr, word);
          mem[addr[7:0]] = word;
          prog_words++;
        end
        else if (n == 1 && tag == "E" && check_count < max_checks)
        begin
          n = $fscanf(fd, "%s %h %h", name, addr, word);
          check_name[check_count] = name;
          check_addr[check_count] = addr[7:0];
          check_value[check_count] = word;
          check_count++;
        end
      end
      $fclose(fd);
      assert (check_count > 0) else
      begin
        $display("No expected words found in test/rv_testdata.txt");
        fail_count++;
      end
    end
  endtask

  task automatic check_word(input int idx);
    logic [31:0] actual;
    logic        ok;
    actual = mem[check_addr[idx]];
    ok = actual == check_value[idx];
    assert (ok) else
    begin
      $display("Error: test %0s expected %08h actual %08h",
               check_name[idx], check_value[idx], actual);
      fail_count++;
    end
    if (ok)
    begin
      $display("Test %0s passed", check_name[idx]);
      pass_count++;
    end
  endtask

  // Core must stay halted with the memory port idle
  task automatic watch_halted_core();
    logic quiet;
    quiet = 1'b1;
    repeat (drain_cycles)
    begin
      @(negedge clk);
      if (!halt || mem_req)
        quiet = 1'b0;
    end
    assert (quiet) else
    begin
      $display("Test halt_hold failed: halt_o dropped or a memory request followed EBREAK");
      fail_count++;
    end
    if (quiet)
    begin
      $display("Test halt_hold passed");
      pass_count++;
    end
  endtask

  // Memory model with 0 to 3 wait cycles per access
  initial
  begin
    mem_ack = 1'b0;
    mem_rdata = '0;
    rng_state = 32'h41e0;
    wait_left = 0;
    forever
    begin
      @(negedge clk);
      if (rst || mem_ack)
        mem_ack = 1'b0;
      else if (mem_req)
      begin
        if (wait_left == 0)
        begin
          mem_ack = 1'b1;
          mem_rdata = mem[mem_addr[9:2]];
          if (mem_we)
            mem[mem_addr[9:2]] = mem_wdata;
          rng_state = xorshift32(rng_state);
          wait_left = int'(rng_state % 4);
        end
        else
          wait_left--;
      end
    end
  end

  initial
  begin
    rst = 1'b1;
    check_count = 0;
    prog_words = 0;
    pass_count = 0;
    fail_count = 0;
    // Fill tracks the word index so stray writes show up
    for (int i = 0; i < mem_words; i++)
      mem[i] = {24'hbad000, 8'(i)};
    read_data_file();
    cycle_limit = prog_words * inst_per_word * cycles_per_inst;

    repeat (10) @(negedge clk);
    rst = 1'b0;

    cycle_count = 0;
    while (!halt && cycle_count < cycle_limit)
    begin
      @(negedge clk);
      cycle_count++;
    end

    assert (halt) else
    begin
      $display("Timeout: halt_o still low after %0d cycles", cycle_limit);
      fail_count++;
    end
    if (halt)
    begin
      watch_halted_core();
      for (int i = 0; i < check_count; i++)
        check_word(i);
    end

    $display("Tests: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== test/rv_testdata.txt ====
# P <word index hex> <instruction word hex>, unlisted words hold bad000 plus index
# E <test name> <word index hex> <expected final word hex>
P 00 12300093 # addi x1, x0, 0x123
P 01 ff000113 # addi x2, x0, -16
P 02 002081b3 # add x3, x1, x2
P 03 10302023 # sw x3, 0x100(x0)
P 04 402081b3 # sub x3, x1, x2
P 05 10302223 # sw x3, 0x104(x0)
P 06 0020f1b3 # and x3, x1, x2
P 07 10302423 # sw x3, 0x108(x0)
P 08 0020e1b3 # or x3, x1, x2
P 09 10302623 # sw x3, 0x10c(x0)
P 0a 0020c1b3 # xor x3, x1, x2
P 0b 10302823 # sw x3, 0x110(x0)
P 0c 001121b3 # slt x3, x2, x1
P 0d 10302a23 # sw x3, 0x114(x0)
P 0e fdd08193 # addi x3, x1, -0x23
P 0f 10302c23 # sw x3, 0x118(x0)
P 10 0f00f193 # andi x3, x1, 0xf0
P 11 10302e23 # sw x3, 0x11c(x0)
P 12 7000e193 # ori x3, x1, 0x700
P 13 12302023 # sw x3, 0x120(x0)
P 14 fff0c193 # xori x3, x1, -1
P 15 12302223 # sw x3, 0x124(x0)
P 16 123451b7 # lui x3, 0x12345
P 17 12302423 # sw x3, 0x128(x0)
P 18 12802203 # lw x4, 0x128(x0)
P 19 06720213 # addi x4, x4, 0x67
P 1a 12402623 # sw x4, 0x12c(x0)
P 1b 00500013 # addi x0, x0, 5
P 1c 12002823 # sw x0, 0x130(x0)
P 1d 05500293 # addi x5, x0, 0x55
P 1e 00208463 # beq x1, x2, +8 not taken
P 1f 12502a23 # sw x5, 0x134(x0)
P 20 00108463 # beq x1, x1, +8 taken
P 21 12502c23 # sw x5, 0x138(x0) skipped
P 22 00109463 # bne x1, x1, +8 not taken
P 23 12502e23 # sw x5, 0x13c(x0)
P 24 00209463 # bne x1, x2, +8 taken
P 25 14502023 # sw x5, 0x140(x0) skipped
P 26 0080036f # jal x6, +8
P 27 14502223 # sw x5, 0x144(x0) skipped
P 28 14602423 # sw x6, 0x148(x0) link is 0x9c
P 29 00100073 # ebreak
P 2a 14502623 # sw x5, 0x14c(x0) never runs
P 2b 14502823 # sw x5, 0x150(x0) never runs
E add 40 00000113
E sub 41 00000133
E and 42 00000120
E or 43 fffffff3
E xor 44 fffffed3
E slt 45 00000001
E addi 46 00000100
E andi 47 00000020
E ori 48 00000723
E xori 49 fffffedc
E lui 4a 12345000
E load_store 4b 12345067
E x0_zero 4c 00000000
E beq_not_taken 4d 00000055
E beq_taken 4e bad0004e
E bne_not_taken 4f 00000055
E bne_taken 50 bad00050
E jal_skip 51 bad00051
E jal_link 52 0000009c
E after_ebreak_1 53 bad00053
E after_ebreak_2 54 bad00054

// ==== flist.f ====
source/rv_pkg.sv
source/rv_regfile.sv
source/rv_bus_arbiter.sv
source/rv_fetch.sv
source/rv_decode.sv
source/rv_execute.sv
source/rv_core.sv
test/tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "Run reported a failure, see $(LOG)"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || \
		{ echo "Run ended without a result, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
